/* src/mil1553_cfg.svh */
//////////////////////////////////////////////////
// Decoder timing counts for 8x line oversampling
// Accepted command/status and data sync patterns
//////////////////////////////////////////////////
`ifndef MIL1553_CFG_SVH
`define MIL1553_CFG_SVH

// Oversampling and word geometry
`define MIL_SAMPLES_PER_BIT 4'd8
`define MIL_SYNC_LEN        24
`define MIL_WORD_BITS       5'd17

// Sample counter values within a word window
`define MIL_CNT_IDLE        8'hFF
`define MIL_WORD_END        8'd131
`define MIL_HOLD_END        8'd132

//////////////////////////////////////////////////
// Sync patterns, newest sample in bit 0
//////////////////////////////////////////////////

// Command/status sync, high then low
`define MIL_CSW_SYNC_0      24'h7FF000
`define MIL_CSW_SYNC_1      24'h7FF800
`define MIL_CSW_SYNC_2      24'hFFE001
`define MIL_CSW_SYNC_3      24'hFFF000

// Data sync, low then high
`define MIL_DW_SYNC_0       24'h0007FF
`define MIL_DW_SYNC_1       24'h001FFF
`define MIL_DW_SYNC_2       24'h000FFF

`endif

/* src/mil1553_word_pkg.sv */
//////////////////////////////////////////////////
// 1553 word and command field types
//////////////////////////////////////////////////
package mil1553_word_pkg;

   // Received word, bit 0 is the first bit on the line
   typedef logic [15:0] word_t;

   // Command word fields
   typedef logic [4:0] rt_addr_t;
   typedef logic [4:0] subaddr_t;
   typedef logic [4:0] wcnt_mcode_t;

   // Kind of word being received, taken from its sync
   typedef enum logic [1:0] {
      kind_none = 2'b00,
      kind_csw  = 2'b01,
      kind_dw   = 2'b10
   } word_kind_t;

endpackage

/* src/mil1553_dec_pkg.sv */
//////////////////////////////////////////////////
// Decoder counter and sync register types
//////////////////////////////////////////////////
`include "mil1553_cfg.svh"

package mil1553_dec_pkg;

   // Sample count within a word window
   typedef logic [7:0] sample_cnt_t;

   // Bit position within a word, parity is bit 16
   typedef logic [4:0] bit_idx_t;

   // Line history used for sync matching
   typedef logic [`MIL_SYNC_LEN-1:0] sync_sreg_t;

endpackage

/* src/sync_detector.sv */
//////////////////////////////////////////////////
// Line sample taps, transition detect and
// command/status and data sync matching
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "mil1553_cfg.svh"

module sync_detector (
   input  logic dec_clk,
   input  logic rst_n,
   input  logic rx_data,
   output logic data_bit,
   output logic sync_csw,
   output logic sync_dw
);
   import mil1553_dec_pkg::*;

   // Tap 0 holds the newest sample, tap 4 the oldest
   logic [4:0] tap_sreg;
   sync_sreg_t sync_sreg;
   logic       line_edge;
   logic       csw_match;
   logic       dw_match;
   logic       csw_match_d;
   logic       dw_match_d;

   // Line history, taps feed the sync window
   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         tap_sreg  <= '0;
         sync_sreg <= '0;
      end else begin
         tap_sreg  <= {tap_sreg[3:0], rx_data};
         sync_sreg <= {sync_sreg[`MIL_SYNC_LEN-2:0], tap_sreg[4]};
      end
   end

   // Mid-bit transition right after the sync window
   assign line_edge = tap_sreg[1] ^ tap_sreg[0];

   // Bit value is the inverted level at the middle tap
   assign data_bit = ~tap_sreg[2];

   assign csw_match = (sync_sreg == `MIL_CSW_SYNC_0) || (sync_sreg == `MIL_CSW_SYNC_1) ||
                      (sync_sreg == `MIL_CSW_SYNC_2) || (sync_sreg == `MIL_CSW_SYNC_3);
   assign dw_match  = (sync_sreg == `MIL_DW_SYNC_0) || (sync_sreg == `MIL_DW_SYNC_1) ||
                      (sync_sreg == `MIL_DW_SYNC_2);

   // Keep a match for one extra cycle so a late edge still qualifies
   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         csw_match_d <= 1'b0;
         dw_match_d  <= 1'b0;
      end else begin
         csw_match_d <= csw_match;
         dw_match_d  <= dw_match;
      end
   end

   assign sync_csw = (csw_match || csw_match_d) && line_edge;
   assign sync_dw  = (dw_match || dw_match_d) && line_edge;

   // Only one sync kind may start a word
   a_sync_exclusive: assert property (@(posedge dec_clk) disable iff (!rst_n)
      !(sync_csw && sync_dw));

endmodule

/* src/word_timer.sv */
//////////////////////////////////////////////////
// Word window, sample counter, bit strobe and
// word kind hold
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "mil1553_cfg.svh"

module word_timer (
   input  logic                         dec_clk,
   input  logic                         rst_n,
   input  logic                         sync_csw,
   input  logic                         sync_dw,
   output logic                         sample,
   output mil1553_dec_pkg::bit_idx_t    bit_idx,
   output mil1553_word_pkg::word_kind_t word_kind,
   output logic                         word_done
);
   import mil1553_dec_pkg::*;
   import mil1553_word_pkg::*;

   logic        win_en;
   logic        sync_any;
   sample_cnt_t sample_cnt;

   assign sync_any = sync_csw || sync_dw;

   // Window opens on a sync and closes at the end of the parity bit
   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         win_en <= 1'b0;
      end else if (sync_any) begin
         win_en <= 1'b1;
      end else if (sample_cnt == `MIL_WORD_END) begin
         win_en <= 1'b0;
      end
   end

   // Preset while idle, a new sync restarts the count
   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         sample_cnt <= `MIL_CNT_IDLE;
      end else if (sync_any || !win_en) begin
         sample_cnt <= `MIL_CNT_IDLE;
      end else begin
         sample_cnt <= sample_cnt + 1'b1;
      end
   end

   // One strobe per bit, second half of the bit
   assign sample = win_en &&
                   ((sample_cnt & sample_cnt_t'(`MIL_SAMPLES_PER_BIT - 1'b1)) == '0);

   assign word_done = (sample_cnt == `MIL_WORD_END);

   // Index of the bit taken on the current strobe
   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         bit_idx <= '0;
      end else if (sync_any || !win_en) begin
         bit_idx <= '0;
      end else if (sample) begin
         bit_idx <= bit_idx + 1'b1;
      end
   end

   // Word kind stays until one count past word end
   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         word_kind <= kind_none;
      end else if (sync_csw) begin
         word_kind <= kind_csw;
      end else if (sync_dw) begin
         word_kind <= kind_dw;
      end else if (sample_cnt == `MIL_HOLD_END) begin
         word_kind <= kind_none;
      end
   end

   // 16 data bits and parity, never more strobes per window
   a_bit_idx_range: assert property (@(posedge dec_clk) disable iff (!rst_n)
      sample |-> (bit_idx < `MIL_WORD_BITS));

endmodule

/* src/word_assembler.sv */
//////////////////////////////////////////////////
// Bit shifter, odd parity check and registered
// word outputs
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "mil1553_cfg.svh"

module word_assembler (
   input  logic                         dec_clk,
   input  logic                         rst_n,
   input  logic                         data_bit,
   input  logic                         sample,
   input  logic                         word_done,
   input  mil1553_word_pkg::word_kind_t word_kind,
   output mil1553_word_pkg::word_t      rx_dword,
   output logic                         rx_dval,
   output logic                         rx_csw,
   output logic                         rx_dw,
   output logic                         rx_perr,
   output logic                         parity_bit
);
   import mil1553_word_pkg::*;

   // First bit on the line ends up in bit 0, parity in the top bit
   logic [`MIL_WORD_BITS-1:0] bit_sreg;

   always_ff @(posedge dec_clk) begin
      if (sample) begin
         bit_sreg <= {data_bit, bit_sreg[`MIL_WORD_BITS-1:1]};
      end
   end

   // Outputs are zero outside the valid cycle
   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_dword   <= '0;
         rx_dval    <= 1'b0;
         rx_perr    <= 1'b0;
         parity_bit <= 1'b0;
      end else if (word_done) begin
         rx_dword   <= bit_sreg[$bits(word_t)-1:0];
         rx_dval    <= 1'b1;
         // Even count of ones over all 17 bits
         rx_perr    <= ~(^bit_sreg);
         parity_bit <= bit_sreg[`MIL_WORD_BITS-1];
      end else begin
         rx_dword   <= '0;
         rx_dval    <= 1'b0;
         rx_perr    <= 1'b0;
         parity_bit <= 1'b0;
      end
   end

   assign rx_csw = (word_kind == kind_csw);
   assign rx_dw  = (word_kind == kind_dw);

   // Each word is reported exactly once
   a_dval_pulse: assert property (@(posedge dec_clk) disable iff (!rst_n)
      rx_dval |=> !rx_dval);

endmodule

/* src/command_field_capture.sv */
//////////////////////////////////////////////////
// Command word field registers, lastword clear
//////////////////////////////////////////////////
`timescale 1ns/10ps

module command_field_capture (
   input  logic                          dec_clk,
   input  logic                          rst_n,
   input  logic                          data_bit,
   input  logic                          sample,
   input  mil1553_dec_pkg::bit_idx_t     bit_idx,
   input  mil1553_word_pkg::word_kind_t  word_kind,
   input  logic                          lastword,
   output mil1553_word_pkg::rt_addr_t    rt_address,
   output logic                          tr,
   output mil1553_word_pkg::subaddr_t    sub_address,
   output mil1553_word_pkg::wcnt_mcode_t dwcnt_mcode
);
   import mil1553_word_pkg::*;

   logic csw_sample;

   // Only bits of a command/status word feed the fields
   assign csw_sample = sample && (word_kind == kind_csw);

   //////////////////////////////////////////////////
   // Fields shift in from the top so that field bit 0
   // holds the earliest word bit
   //////////////////////////////////////////////////

   // RT address, word bits 0 to 4
   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         rt_address <= '0;
      end else if (lastword) begin
         rt_address <= '0;
      end else if (csw_sample && (bit_idx < 5'd5)) begin
         rt_address <= {data_bit, rt_address[4:1]};
      end
   end

   // Transmit/receive, word bit 5
   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         tr <= 1'b0;
      end else if (lastword) begin
         tr <= 1'b0;
      end else if (csw_sample && (bit_idx == 5'd5)) begin
         tr <= data_bit;
      end
   end

   // Subaddress, word bits 6 to 10
   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         sub_address <= '0;
      end else if (lastword) begin
         sub_address <= '0;
      end else if (csw_sample && (bit_idx >= 5'd6) && (bit_idx <= 5'd10)) begin
         sub_address <= {data_bit, sub_address[4:1]};
      end
   end

   // Word count or mode code, bits 11 to 15, kept over lastword
   always_ff @(posedge dec_clk or negedge rst_n) begin
      if (!rst_n) begin
         dwcnt_mcode <= '0;
      end else if (csw_sample && (bit_idx >= 5'd11) && (bit_idx <= 5'd15)) begin
         dwcnt_mcode <= {data_bit, dwcnt_mcode[4:1]};
      end
   end

endmodule

/* src/mil1553_decoder.sv */
//////////////////////////////////////////////////
// 1553 receive decoder top level
//////////////////////////////////////////////////
`timescale 1ns/10ps

module mil1553_decoder (
   input  logic                          dec_clk,
   input  logic                          rst_n,
   input  logic                          rx_data,
   input  logic                          lastword,
   output mil1553_word_pkg::word_t       rx_dword,
   output logic                          rx_dval,
   output logic                          rx_csw,
   output logic                          rx_dw,
   output logic                          rx_perr,
   output logic                          parity_bit,
   output mil1553_word_pkg::rt_addr_t    rt_address,
   output logic                          tr,
   output mil1553_word_pkg::subaddr_t    sub_address,
   output mil1553_word_pkg::wcnt_mcode_t dwcnt_mcode
);
   import mil1553_word_pkg::*;
   import mil1553_dec_pkg::*;

   logic       data_bit;
   logic       sync_csw;
   logic       sync_dw;
   logic       sample;
   logic       word_done;
   bit_idx_t   bit_idx;
   word_kind_t word_kind;

   // Line front end
   sync_detector sync_detector_i (
      .dec_clk  (dec_clk),
      .rst_n    (rst_n),
      .rx_data  (rx_data),
      .data_bit (data_bit),
      .sync_csw (sync_csw),
      .sync_dw  (sync_dw)
   );

   word_timer word_timer_i (
      .dec_clk   (dec_clk),
      .rst_n     (rst_n),
      .sync_csw  (sync_csw),
      .sync_dw   (sync_dw),
      .sample    (sample),
      .bit_idx   (bit_idx),
      .word_kind (word_kind),
      .word_done (word_done)
   );

   word_assembler word_assembler_i (
      .dec_clk    (dec_clk),
      .rst_n      (rst_n),
      .data_bit   (data_bit),
      .sample     (sample),
      .word_done  (word_done),
      .word_kind  (word_kind),
      .rx_dword   (rx_dword),
      .rx_dval    (rx_dval),
      .rx_csw     (rx_csw),
      .rx_dw      (rx_dw),
      .rx_perr    (rx_perr),
      .parity_bit (parity_bit)
   );

   // Field capture runs alongside the word shifter
   command_field_capture command_field_capture_i (
      .dec_clk     (dec_clk),
      .rst_n       (rst_n),
      .data_bit    (data_bit),
      .sample      (sample),
      .bit_idx     (bit_idx),
      .word_kind   (word_kind),
      .lastword    (lastword),
      .rt_address  (rt_address),
      .tr          (tr),
      .sub_address (sub_address),
      .dwcnt_mcode (dwcnt_mcode)
   );

endmodule

/* testbench/tb_mil1553_decoder.sv */
//////////////////////////////////////////////////
// Testbench for the 1553 receive decoder
// Manchester line driver, word table, field model
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "mil1553_cfg.svh"

module tb_mil1553_decoder;

   localparam int N_ROWS      = 14;
   localparam int CYCLE_LIMIT = 2 * N_ROWS * 200;
   localparam int DVAL_WAIT   = 200;

   // One table row per word on the line
   typedef struct packed {
      logic        is_csw;
      logic [15:0] word;
      logic        corrupt;
      logic        clear_after;
   } row_t;

   // Everything the DUT presents in an rx_dval cycle
   typedef struct packed {
      logic        csw;
      logic        dw;
      logic        perr;
      logic        pbit;
      logic [15:0] word;
      logic [4:0]  rt;
      logic        tr;
      logic [4:0]  sub;
      logic [4:0]  wc;
   } capture_t;

   logic        dec_clk;
   logic        rst_n;
   logic        rx_data;
   logic        lastword;
   logic [15:0] rx_dword;
   logic        rx_dval;
   logic        rx_csw;
   logic        rx_dw;
   logic        rx_perr;
   logic        parity_bit;
   logic [4:0]  rt_address;
   logic        tr;
   logic [4:0]  sub_address;
   logic [4:0]  dwcnt_mcode;

   row_t        rows [N_ROWS];
   capture_t    cap_q [$];
   capture_t    mon_cap;
   integer      seed;
   int          err_cnt;
   int          check_cnt;
   int          cycle_cnt = 0;
   string       stage_name;

   // Expected command fields
   logic [4:0]  exp_rt;
   logic        exp_tr;
   logic [4:0]  exp_sub;
   logic [4:0]  exp_wc;

   mil1553_decoder mil1553_decoder_i (
      .dec_clk     (dec_clk),
      .rst_n       (rst_n),
      .rx_data     (rx_data),
      .lastword    (lastword),
      .rx_dword    (rx_dword),
      .rx_dval     (rx_dval),
      .rx_csw      (rx_csw),
      .rx_dw       (rx_dw),
      .rx_perr     (rx_perr),
      .parity_bit  (parity_bit),
      .rt_address  (rt_address),
      .tr          (tr),
      .sub_address (sub_address),
      .dwcnt_mcode (dwcnt_mcode)
   );

   always #5 dec_clk = ~dec_clk;

   // Run limit from the table length
   always @(posedge dec_clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
         $display("Test failures found");
         $finish;
      end
   end

   // Collect the outputs of every valid word
   always @(negedge dec_clk) begin
      if (rst_n && rx_dval) begin
         mon_cap.csw  = rx_csw;
         mon_cap.dw   = rx_dw;
         mon_cap.perr = rx_perr;
         mon_cap.pbit = parity_bit;
         mon_cap.word = rx_dword;
         mon_cap.rt   = rt_address;
         mon_cap.tr   = tr;
         mon_cap.sub  = sub_address;
         mon_cap.wc   = dwcnt_mcode;
         cap_q.push_back(mon_cap);
      end else if (rst_n) begin
         assert ((rx_dword == 16'h0000) && !rx_perr && !parity_bit) else begin
            err_cnt++;
            $display("[ERROR] %0t: word outputs not zero outside rx_dval", $time);
         end
      end
   end

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   task automatic check_value(input string what, input logic [15:0] got,
                              input logic [15:0] exp);
      check_cnt++;
      assert (got === exp) else begin
         err_cnt++;
         $display("[ERROR] %0t: %s: %s is %h, expected %h", $time, stage_name, what, got, exp);
      end
   endtask

   task automatic check_fields(input logic [4:0] rt, input logic tr_bit,
                               input logic [4:0] sub, input logic [4:0] wc);
      check_value("rt_address", rt, exp_rt);
      check_value("tr", tr_bit, exp_tr);
      check_value("sub_address", sub, exp_sub);
      check_value("dwcnt_mcode", wc, exp_wc);
   endtask

   //////////////////////////////////////////////////
   // Line driver
   //////////////////////////////////////////////////

   task automatic drive_level(input logic level, input int n);
      repeat (n) begin
         @(posedge dec_clk);
         rx_data <= level;
      end
   endtask

   // A 1 goes out high then low as the decoder inverts the second half
   task automatic send_bit(input logic b);
      drive_level(b, `MIL_SAMPLES_PER_BIT / 2);
      drive_level(~b, `MIL_SAMPLES_PER_BIT / 2);
   endtask

   // Sync, 16 data bits LSB first, parity, then idle gap
   task automatic send_word(input logic is_csw, input logic [15:0] data, input logic par);
      drive_level(is_csw, `MIL_SYNC_LEN / 2);
      drive_level(~is_csw, `MIL_SYNC_LEN / 2);
      for (int i = 0; i < 16; i++) begin
         send_bit(data[i]);
      end
      send_bit(par);
      drive_level(1'b1, 8);
   endtask

   function automatic row_t make_row(input logic is_csw, input logic [15:0] word,
                                     input logic corrupt, input logic clear_after);
      row_t row;
      row.is_csw      = is_csw;
      row.word        = word;
      row.corrupt     = corrupt;
      row.clear_after = clear_after;
      return row;
   endfunction

   task automatic build_table();
      logic [31:0] rnd;
      rows[0] = make_row(1'b0, 16'hA5C3, 1'b0, 1'b0);
      rows[1] = make_row(1'b1, 16'h3B52, 1'b0, 1'b0);
      rows[2] = make_row(1'b0, 16'h0000, 1'b1, 1'b0);
      rows[3] = make_row(1'b1, 16'hFFFF, 1'b1, 1'b0);
      rows[4] = make_row(1'b0, 16'h1234, 1'b0, 1'b0);
      rows[5] = make_row(1'b1, 16'h7AD9, 1'b0, 1'b1);
      // Command word then a burst of random data words
      rows[6] = make_row(1'b1, 16'h0C41, 1'b0, 1'b0);
      for (int i = 7; i < 12; i++) begin
         rnd = $random(seed);
         rows[i] = make_row(1'b0, rnd[15:0], 1'b0, 1'b0);
      end
      rnd = $random(seed);
      rows[12] = make_row(1'b1, rnd[15:0], 1'b0, 1'b1);
      rnd = $random(seed);
      rows[13] = make_row(1'b0, rnd[15:0], 1'b1, 1'b0);
   endtask

   task automatic apply_row(input int r);
      row_t     row;
      capture_t cap;
      logic     par;
      int       waited;
      row        = rows[r];
      stage_name = $sformatf("row %0d", r);
      // Odd parity over all 17 bits unless the row flips it
      par = ~(^row.word);
      if (row.corrupt) begin
         par = ~par;
      end
      if (row.is_csw) begin
         exp_rt  = row.word[4:0];
         exp_tr  = row.word[5];
         exp_sub = row.word[10:6];
         exp_wc  = row.word[15:11];
      end
      send_word(row.is_csw, row.word, par);
      waited = 0;
      while ((cap_q.size() == 0) && (waited < DVAL_WAIT)) begin
         @(negedge dec_clk);
         waited++;
      end
      if (cap_q.size() == 0) begin
         err_cnt++;
         $display("No rx_dval pulse seen for row %0d within %0d cycles", r, DVAL_WAIT);
      end else begin
         cap = cap_q.pop_front();
         check_value("rx_dword", cap.word, row.word);
         check_value("rx_csw", cap.csw, row.is_csw);
         check_value("rx_dw", cap.dw, !row.is_csw);
         check_value("rx_perr", cap.perr, row.corrupt);
         check_value("parity_bit", cap.pbit, par);
         check_fields(cap.rt, cap.tr, cap.sub, cap.wc);
         assert (cap_q.size() == 0) else begin
            err_cnt++;
            $display("More than one rx_dval pulse seen for row %0d", r);
         end
      end
      if (row.clear_after) begin
         @(posedge dec_clk);
         lastword <= 1'b1;
         @(posedge dec_clk);
         lastword <= 1'b0;
         @(negedge dec_clk);
         // Word count or mode code survives lastword
         exp_rt     = '0;
         exp_tr     = 1'b0;
         exp_sub    = '0;
         stage_name = $sformatf("row %0d lastword", r);
         check_fields(rt_address, tr, sub_address, dwcnt_mcode);
      end
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial begin
      dec_clk    = 1'b0;
      rst_n      = 1'b0;
      rx_data    = 1'b1;
      lastword   = 1'b0;
      err_cnt    = 0;
      check_cnt  = 0;
      seed       = 32'h2b36;
      exp_rt     = '0;
      exp_tr     = 1'b0;
      exp_sub    = '0;
      exp_wc     = '0;
      stage_name = "after reset";
      build_table();
      repeat (8) @(posedge dec_clk);
      rst_n <= 1'b1;
      drive_level(1'b1, 40);
      @(negedge dec_clk);
      check_value("rx_dval", rx_dval, 16'h0);
      check_value("rx_csw", rx_csw, 16'h0);
      check_value("rx_dw", rx_dw, 16'h0);
      check_value("rx_perr", rx_perr, 16'h0);
      check_fields(rt_address, tr, sub_address, dwcnt_mcode);
      for (int r = 0; r < N_ROWS; r++) begin
         apply_row(r);
      end
      drive_level(1'b1, 20);
      $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* verilog.f */
+incdir+src
src/mil1553_word_pkg.sv
src/mil1553_dec_pkg.sv
src/sync_detector.sv
src/word_timer.sv
src/word_assembler.sv
src/command_field_capture.sv
src/mil1553_decoder.sv
testbench/tb_mil1553_decoder.sv
